// File: dv/decode_tb.sv
`timescale 1ns/1ps

module decode_tb import decode_pkg::*; ();

  typedef enum logic [3:0] {
    k_bubble, k_alu_reg, k_alu_imm, k_upper, k_load, k_store, k_branch,
    k_illegal, k_ebreak, k_ecall
  } kind_type;

  typedef struct packed {
    logic [xlen-1:0] instr0;
    logic [xlen-1:0] instr1;
    logic valid;
    logic hold;
    logic clear;
    execute_info_type ex;
    writeback_type wb;
    kind_type kind0;
    unit_type unit0;
    alu_op_type alu0;
    logic [xlen-1:0] imm0;
    logic [3:0] cause0;
    kind_type kind1;
    logic [3:0][4:0] src; // Source registers of rdata0_1, rdata0_2, rdata1_1, rdata1_2.
    logic stall;
  } row_type;

  localparam int preload_count = 8;
  localparam execute_info_type no_ex = '0;

  logic clock;
  logic reset;
  fetch_in_type fetch;
  execute_info_type ex;
  logic hold;
  logic clear;
  writeback_type wb;
  logic stall;
  issue_out_type issue;

  row_type rows[$];
  row_type exp_row;
  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] exp_data [4];
  logic [xlen-1:0] model [32]; // Register contents as the testbench expects them.
  int cycles = 0;
  int cycle_limit = 1000;
  int checks = 0;
  int operation_errors = 0;
  int word_errors = 0;
  int cause_errors = 0;
  int bit_errors = 0;
  int unit_errors = 0;
  int alu_errors = 0;

  decode_top i_dut (.clock, .reset, .fetch, .ex, .hold, .clear, .wb, .stall, .issue);

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not complete", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // Enables and flags that each instruction class must raise.
  function automatic operation_type expected_op(input kind_type k);
    operation_type o;
    o = '0;
    o.valid = !(k inside {k_bubble, k_illegal});
    o.wren = k inside {k_alu_reg, k_alu_imm, k_upper, k_load};
    o.rden1 = k inside {k_alu_reg, k_alu_imm, k_load, k_store, k_branch};
    o.rden2 = k inside {k_alu_reg, k_store, k_branch};
    o.load = (k == k_load);
    o.store = (k == k_store);
    o.branch = (k == k_branch);
    o.ebreak = (k == k_ebreak);
    o.ecall = (k == k_ecall);
    o.exception = k inside {k_illegal, k_ebreak, k_ecall};
    return o;
  endfunction

  function automatic execute_info_type ex_of(input logic load, input logic division,
      input logic csr_write, input logic [reg_addr_width-1:0] waddr);
    execute_info_type e;
    e = '0;
    e.load = load;
    e.division = division;
    e.csr_write = csr_write;
    e.waddr = waddr;
    return e;
  endfunction

  task automatic add_row(input logic [xlen-1:0] instr0, input logic [xlen-1:0] instr1,
      input execute_info_type ex_row, input logic [2:0] ctrl, input logic [4:0] wb_addr,
      input logic [xlen-1:0] wb_data, input kind_type kind0, input unit_type unit0,
      input alu_op_type alu0, input logic [xlen-1:0] imm0, input logic [3:0] cause0,
      input kind_type kind1, input logic [3:0][4:0] src, input logic stall_exp);
    row_type r;
    r.instr0 = instr0;
    r.instr1 = instr1;
    {r.valid, r.hold, r.clear} = ctrl;
    r.ex = ex_row;
    r.wb.wren = (wb_addr != 5'd0);
    r.wb.waddr = wb_addr;
    r.wb.wdata = wb_data;
    r.kind0 = kind0;
    r.unit0 = unit0;
    r.alu0 = alu0;
    r.imm0 = imm0;
    r.cause0 = cause0;
    r.kind1 = kind1;
    r.src = src;
    r.stall = stall_exp;
    rows.push_back(r);
  endtask

  task automatic check_operation(input string name, input operation_type got,
      input operation_type exp);
    checks++;
    if (got !== exp) begin
      operation_errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] got,
      input logic [xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      word_errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cause(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      cause_errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      bit_errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_unit(input string name, input unit_type got, input unit_type exp);
    checks++;
    if (got !== exp) begin
      unit_errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_alu(input string name, input alu_op_type got, input alu_op_type exp);
    checks++;
    if (got !== exp) begin
      alu_errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_issue();
    check_word("instr0.pc", issue.instr0.pc, exp_pc);
    check_word("instr1.pc", issue.instr1.pc, exp_pc + 32'd4); // Second word of the bundle.
    check_word("instr0.instr", issue.instr0.instr, exp_row.instr0);
    check_word("instr1.instr", issue.instr1.instr, exp_row.instr1);
    check_operation("instr0.op", issue.instr0.op, expected_op(exp_row.kind0));
    check_unit("instr0.unit", issue.instr0.unit, exp_row.unit0);
    check_alu("instr0.alu_op", issue.instr0.alu_op, exp_row.alu0);
    check_word("instr0.imm", issue.instr0.imm, exp_row.imm0);
    check_cause("instr0.ecause", issue.instr0.ecause, exp_row.cause0);
    check_word("instr0.etval", issue.instr0.etval,
      (exp_row.cause0 != 4'd0) ? exp_row.instr0 : '0);
    check_operation("instr1.op", issue.instr1.op, expected_op(exp_row.kind1));
    check_cause("instr1.ecause", issue.instr1.ecause, 4'd0); // Slot 1 never traps.
    check_word("rdata0_1", issue.rdata0_1, exp_data[0]);
    check_word("rdata0_2", issue.rdata0_2, exp_data[1]);
    check_word("rdata1_1", issue.rdata1_1, exp_data[2]);
    check_word("rdata1_2", issue.rdata1_2, exp_data[3]);
    check_bit("issue.stall", issue.stall, exp_row.stall);
  endtask

  // Control column is {valid, hold, clear}.
  task automatic build_table();
    add_row(32'h002082b3, 32'h40418333, no_ex, 3'b100, 5'd0, 32'h0,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    add_row(32'h80340393, 32'habcde4b7, no_ex, 3'b100, 5'd0, 32'h0,
      k_alu_imm, unit_alu, alu_add, 32'hfffff803, 4'd0, k_upper, {5'd8, 15'd0}, 1'b0);
    add_row(32'hff812503, 32'h12345597, no_ex, 3'b100, 5'd0, 32'h0,
      k_load, unit_load, alu_add, 32'hfffffff8, 4'd0, k_upper, {5'd2, 15'd0}, 1'b0);
    add_row(32'h0041aa23, 32'h0062f633, no_ex, 3'b100, 5'd0, 32'h0,
      k_store, unit_store, alu_add, 32'h14, 4'd0, k_alu_reg, {5'd3, 5'd4, 5'd5, 5'd6}, 1'b0);
    add_row(32'hfe208ee3, 32'h00339693, no_ex, 3'b100, 5'd0, 32'h0,
      k_branch, unit_branch, alu_add, 32'hfffffffc, 4'd0, k_alu_imm, {5'd1, 5'd2, 5'd7, 5'd0}, 1'b0);
    add_row(32'h80000737, 32'h40445793, no_ex, 3'b100, 5'd0, 32'h0,
      k_upper, unit_alu, alu_lui, 32'h80000000, 4'd0, k_alu_imm, {10'd0, 5'd8, 5'd0}, 1'b0);
    // Exceptions; the last row looks like ebreak but has rd set.
    add_row(32'h00000000, 32'hffffffff, no_ex, 3'b100, 5'd0, 32'h0,
      k_illegal, unit_alu, alu_add, 32'h0, 4'd2, k_bubble, 20'd0, 1'b0);
    add_row(32'h00100073, 32'hff812503, no_ex, 3'b100, 5'd0, 32'h0,
      k_ebreak, unit_system, alu_add, 32'h0, 4'd3, k_bubble, 20'd0, 1'b0);
    add_row(32'h00000073, 32'h00000013, no_ex, 3'b100, 5'd0, 32'h0,
      k_ecall, unit_system, alu_add, 32'h0, 4'd11, k_alu_imm, 20'd0, 1'b0);
    add_row(32'h001000f3, 32'h40418333, no_ex, 3'b100, 5'd0, 32'h0,
      k_illegal, unit_system, alu_add, 32'h0, 4'd2, k_alu_reg, {10'd0, 5'd3, 5'd4}, 1'b0);
    // Hazards against execute.
    add_row(32'h002082b3, 32'h40418333, ex_of(1'b1, 1'b0, 1'b0, 5'd2), 3'b100, 5'd0, 32'h0,
      k_bubble, unit_alu, alu_add, 32'h0, 4'd0, k_bubble, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b1);
    add_row(32'h002082b3, 32'h40418333, ex_of(1'b1, 1'b0, 1'b0, 5'd4), 3'b100, 5'd0, 32'h0,
      k_bubble, unit_alu, alu_add, 32'h0, 4'd0, k_bubble, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b1);
    add_row(32'h002082b3, 32'h40418333, ex_of(1'b1, 1'b0, 1'b0, 5'd0), 3'b100, 5'd0, 32'h0,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    add_row(32'h002082b3, 32'h40418333, ex_of(1'b0, 1'b0, 1'b0, 5'd1), 3'b100, 5'd0, 32'h0,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    add_row(32'h002082b3, 32'h40418333, ex_of(1'b0, 1'b1, 1'b0, 5'd0), 3'b100, 5'd0, 32'h0,
      k_bubble, unit_alu, alu_add, 32'h0, 4'd0, k_bubble, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b1);
    add_row(32'h002082b3, 32'h40418333, ex_of(1'b0, 1'b0, 1'b1, 5'd0), 3'b100, 5'd0, 32'h0,
      k_bubble, unit_alu, alu_add, 32'h0, 4'd0, k_bubble, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b1);
    // Clear over a hazard, then a bundle without valid.
    add_row(32'h002082b3, 32'h40418333, ex_of(1'b1, 1'b0, 1'b0, 5'd1), 3'b101, 5'd0, 32'h0,
      k_bubble, unit_alu, alu_add, 32'h0, 4'd0, k_bubble, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    add_row(32'h002082b3, 32'h40418333, no_ex, 3'b000, 5'd0, 32'h0,
      k_bubble, unit_alu, alu_add, 32'h0, 4'd0, k_bubble, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    // Two held cycles keep the LUI bundle.
    add_row(32'h80000737, 32'h40445793, no_ex, 3'b100, 5'd0, 32'h0,
      k_upper, unit_alu, alu_lui, 32'h80000000, 4'd0, k_alu_imm, {10'd0, 5'd8, 5'd0}, 1'b0);
    add_row(32'h002082b3, 32'h40418333, no_ex, 3'b110, 5'd0, 32'h0,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    add_row(32'h002082b3, 32'h40418333, no_ex, 3'b110, 5'd0, 32'h0,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    add_row(32'h002082b3, 32'h40418333, no_ex, 3'b100, 5'd0, 32'h0,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    // Write x1 while it is read, then read it again.
    add_row(32'h002082b3, 32'h40418333, no_ex, 3'b100, 5'd1, 32'h0badf00d,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
    add_row(32'h002082b3, 32'h40418333, no_ex, 3'b100, 5'd0, 32'h0,
      k_alu_reg, unit_alu, alu_add, 32'h0, 4'd0, k_alu_reg, {5'd1, 5'd2, 5'd3, 5'd4}, 1'b0);
  endtask

  initial begin
    row_type row;
    int total;
    clock = 1'b0;
    reset = 1'b0;
    fetch = '0;
    ex = '0;
    hold = 1'b0;
    clear = 1'b0;
    wb = '0;
    exp_pc = '0;
    void'($urandom(32'hc62a));
    foreach (model[i]) model[i] = '0;
    build_table();
    cycle_limit = rows.size() + preload_count + 20;

    repeat (2) @(posedge clock);
    @(negedge clock);
    check_operation("reset instr0.op", issue.instr0.op, '0);
    check_operation("reset instr1.op", issue.instr1.op, '0);
    check_bit("reset issue.stall", issue.stall, 1'b0);
    check_bit("reset stall", stall, 1'b0);
    reset = 1'b1;

    for (int i = 1; i <= preload_count; i++) begin
      wb.wren = 1'b1;
      wb.waddr = 5'(i);
      wb.wdata = $urandom();
      model[i] = wb.wdata;
      @(negedge clock);
    end
    wb = '0;

    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      fetch.pc0 = 32'h1000 + 32'(i * 8);
      fetch.instr0 = row.instr0;
      fetch.instr1 = row.instr1;
      fetch.valid = row.valid;
      ex = row.ex;
      hold = row.hold;
      clear = row.clear;
      wb = row.wb;
      if (!row.hold) begin
        exp_row = row;
        exp_pc = 32'h1000 + 32'(i * 8);
        for (int k = 0; k < 4; k++) exp_data[k] = model[row.src[3-k]];
      end
      if (row.wb.wren) model[row.wb.waddr] = row.wb.wdata; // Lands at the coming edge.
      #2;
      check_bit("stall", stall, row.stall);
      @(negedge clock);
      compare_issue();
    end

    total = operation_errors + word_errors + cause_errors + bit_errors + unit_errors +
            alu_errors;
    $display("Errors: operation %0d, word %0d, cause %0d, bit %0d, unit %0d, alu %0d, %0d checks",
             operation_errors, word_errors, cause_errors, bit_errors, unit_errors, alu_errors,
             checks);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: files.f
source/decode_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/decode_stage.sv
source/decode_top.sv
dv/decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_tb -f files.f -o decode_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/decode_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi

// File: source/decode_pkg.sv
package decode_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  // Major opcodes.
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_fence = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // Fixed system encodings.
  localparam logic [xlen-1:0] instr_ecall = 32'h00000073;
  localparam logic [xlen-1:0] instr_ebreak = 32'h00100073;
  localparam logic [xlen-1:0] instr_mret = 32'h30200073;

  localparam logic [3:0] except_illegal_instruction = 4'd2;
  localparam logic [3:0] except_breakpoint = 4'd3;
  localparam logic [3:0] except_env_call_mach = 4'd11;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_lui, alu_auipc
  } alu_op_type;

  typedef enum logic [2:0] {
    unit_alu, unit_branch, unit_load, unit_store,
    unit_mult, unit_division, unit_csr, unit_system
  } unit_type;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic load;
    logic store;
    logic branch;
    logic jal;
    logic jalr;
    logic mult;
    logic division;
    logic csr_write;
    logic csr_read;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic valid;
    logic exception; // Set by the stage, never by a decoder.
  } operation_type;

  typedef struct packed {
    logic [xlen-1:0] imm;
    operation_type op;
    unit_type unit;
    alu_op_type alu_op;
    logic [2:0] funct3;
  } decoder_out_type;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic [reg_addr_width-1:0] waddr;
    logic [reg_addr_width-1:0] raddr1;
    logic [reg_addr_width-1:0] raddr2;
    logic [xlen-1:0] imm;
    operation_type op;
    unit_type unit;
    alu_op_type alu_op;
    logic [2:0] funct3;
    logic [3:0] ecause;
    logic [xlen-1:0] etval;
  } instr_slot_type;

  typedef struct packed {
    logic [xlen-1:0] pc0;
    logic [xlen-1:0] instr0;
    logic [xlen-1:0] instr1;
    logic valid;
  } fetch_in_type;

  typedef struct packed {
    logic load;
    logic division;
    logic csr_write;
    logic mem_csr_write; // CSR write still in the memory stage.
    logic fence;
    logic [reg_addr_width-1:0] waddr;
    logic stall;
  } execute_info_type;

  typedef struct packed {
    logic wren;
    logic [reg_addr_width-1:0] waddr;
    logic [xlen-1:0] wdata;
  } writeback_type;

  typedef struct packed {
    logic rden;
    logic [reg_addr_width-1:0] raddr;
  } read_port_type;

  typedef struct packed {
    instr_slot_type instr0;
    instr_slot_type instr1;
    logic [xlen-1:0] rdata0_1;
    logic [xlen-1:0] rdata0_2;
    logic [xlen-1:0] rdata1_1;
    logic [xlen-1:0] rdata1_2;
    logic stall;
  } issue_out_type;

  localparam operation_type init_operation = '0;
  localparam issue_out_type init_issue = '0;

endpackage

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
  input logic clock,
  input logic reset,
  input fetch_in_type fetch,
  input decoder_out_type dec0,
  input decoder_out_type dec1,
  output logic [xlen-1:0] instr0_word,
  output logic [xlen-1:0] instr1_word,
  output read_port_type read0_1,
  output read_port_type read0_2,
  output read_port_type read1_1,
  output read_port_type read1_2,
  input logic [xlen-1:0] rdata0_1,
  input logic [xlen-1:0] rdata0_2,
  input logic [xlen-1:0] rdata1_1,
  input logic [xlen-1:0] rdata1_2,
  input execute_info_type ex,
  input logic hold,
  input logic clear,
  output logic stall,
  output issue_out_type issue
);

  issue_out_type r;
  issue_out_type v;
  logic clear_pending;
  logic flush;
  logic load_use;

  assign instr0_word = fetch.instr0;
  assign instr1_word = fetch.instr1;
  assign flush = clear | clear_pending; // Clear seen during hold is applied afterwards.

  always_comb begin
    v = init_issue;

    v.instr0.pc = fetch.pc0;
    v.instr0.instr = fetch.instr0;
    v.instr0.waddr = fetch.instr0[11:7];
    v.instr0.raddr1 = fetch.instr0[19:15];
    v.instr0.raddr2 = fetch.instr0[24:20];
    v.instr0.imm = dec0.imm;
    v.instr0.op = dec0.op;
    v.instr0.unit = dec0.unit;
    v.instr0.alu_op = dec0.alu_op;
    v.instr0.funct3 = dec0.funct3;

    v.instr1.pc = fetch.pc0 + 4;
    v.instr1.instr = fetch.instr1;
    v.instr1.waddr = fetch.instr1[11:7];
    v.instr1.raddr1 = fetch.instr1[19:15];
    v.instr1.raddr2 = fetch.instr1[24:20];
    v.instr1.imm = dec1.imm;
    v.instr1.op = dec1.op;
    v.instr1.unit = dec1.unit;
    v.instr1.alu_op = dec1.alu_op;
    v.instr1.funct3 = dec1.funct3;

    // Illegal first, then breakpoint, then environment call.
    if (!v.instr0.op.valid) begin
      v.instr0.op.exception = 1'b1;
      v.instr0.ecause = except_illegal_instruction;
      v.instr0.etval = v.instr0.instr;
    end else if (v.instr0.op.ebreak) begin
      v.instr0.op.exception = 1'b1;
      v.instr0.ecause = except_breakpoint;
      v.instr0.etval = v.instr0.instr;
    end else if (v.instr0.op.ecall) begin
      v.instr0.op.exception = 1'b1;
      v.instr0.ecause = except_env_call_mach;
      v.instr0.etval = v.instr0.instr;
    end

    if (!v.instr1.op.valid) v.instr1.op = init_operation; // Bubble, not a trap.

    read0_1.rden = v.instr0.op.rden1;
    read0_1.raddr = v.instr0.raddr1;
    read0_2.rden = v.instr0.op.rden2;
    read0_2.raddr = v.instr0.raddr2;
    read1_1.rden = v.instr1.op.rden1;
    read1_1.raddr = v.instr1.raddr1;
    read1_2.rden = v.instr1.op.rden2;
    read1_2.raddr = v.instr1.raddr2;

    load_use = ex.load && (ex.waddr != '0) &&
               ((v.instr0.op.rden1 && v.instr0.raddr1 == ex.waddr) ||
                (v.instr0.op.rden2 && v.instr0.raddr2 == ex.waddr) ||
                (v.instr1.op.rden1 && v.instr1.raddr1 == ex.waddr) ||
                (v.instr1.op.rden2 && v.instr1.raddr2 == ex.waddr));

    v.stall = ex.csr_write | ex.mem_csr_write | ex.division | load_use;

    if (v.stall | ex.stall | ex.fence | flush | !fetch.valid) begin
      v.instr0.op = init_operation;
      v.instr1.op = init_operation;
    end

    if (flush) v.stall = 1'b0;

    v.rdata0_1 = rdata0_1;
    v.rdata0_2 = rdata0_2;
    v.rdata1_1 = rdata1_1;
    v.rdata1_2 = rdata1_2;

    stall = v.stall;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= init_issue;
      clear_pending <= 1'b0;
    end else begin
      clear_pending <= hold & flush;
      if (!hold) r <= v;
    end
  end

  assign issue = r;

  // Held bundle must not move.
  assert property (@(posedge clock) disable iff (!reset) hold |=> $stable(issue));

endmodule

// File: source/decode_top.sv
`timescale 1ns/1ps

module decode_top import decode_pkg::*; (
  input logic clock,
  input logic reset,
  input fetch_in_type fetch,
  input execute_info_type ex,
  input logic hold,
  input logic clear,
  input writeback_type wb,
  output logic stall,
  output issue_out_type issue
);

  decoder_out_type dec0;
  decoder_out_type dec1;
  logic [xlen-1:0] instr0_word;
  logic [xlen-1:0] instr1_word;
  read_port_type read0_1;
  read_port_type read0_2;
  read_port_type read1_1;
  read_port_type read1_2;
  logic [xlen-1:0] rdata0_1;
  logic [xlen-1:0] rdata0_2;
  logic [xlen-1:0] rdata1_1;
  logic [xlen-1:0] rdata1_2;

  instr_decoder #(.full(1'b1)) i_decoder0 (.instr(instr0_word), .dec(dec0));

  // Slot 1 takes only ALU, LUI and AUIPC.
  instr_decoder #(.full(1'b0)) i_decoder1 (.instr(instr1_word), .dec(dec1));

  register_file i_register_file (
    .clock, .reset,
    .read0_1, .read0_2, .read1_1, .read1_2,
    .rdata0_1, .rdata0_2, .rdata1_1, .rdata1_2,
    .wb
  );

  decode_stage i_decode_stage (
    .clock, .reset,
    .fetch,
    .dec0, .dec1,
    .instr0_word, .instr1_word,
    .read0_1, .read0_2, .read1_1, .read1_2,
    .rdata0_1, .rdata0_2, .rdata1_1, .rdata1_2,
    .ex,
    .hold, .clear,
    .stall,
    .issue
  );

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; #(
  parameter bit full = 1'b1
) (
  input logic [xlen-1:0] instr,
  output decoder_out_type dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [reg_addr_width-1:0] rd;
  logic [reg_addr_width-1:0] rs1;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic complex_class;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic alu_op_type alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: return alt ? alu_sub : alu_add;
      3'b001: return alu_sll;
      3'b010: return alu_slt;
      3'b011: return alu_sltu;
      3'b100: return alu_xor;
      3'b101: return alt ? alu_sra : alu_srl;
      3'b110: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    dec = '0;
    dec.funct3 = funct3;
    complex_class = 1'b0;
    case (opcode)
      op_lui, op_auipc: begin
        dec.imm = imm_u;
        dec.alu_op = (opcode == op_lui) ? alu_lui : alu_auipc;
        dec.op.wren = 1'b1;
        dec.op.valid = 1'b1;
      end
      op_imm: begin
        dec.imm = imm_i;
        dec.alu_op = alu_from_funct(funct3, funct3 == 3'b101 && instr[30]);
        dec.op.wren = 1'b1;
        dec.op.rden1 = 1'b1;
        if (funct3 == 3'b001) dec.op.valid = (funct7 == funct7_base);
        else if (funct3 == 3'b101) dec.op.valid = (funct7 == funct7_base || funct7 == funct7_alt);
        else dec.op.valid = 1'b1;
      end
      op_reg: begin
        dec.op.wren = 1'b1;
        dec.op.rden1 = 1'b1;
        dec.op.rden2 = 1'b1;
        if (funct7 == funct7_muldiv) begin
          complex_class = 1'b1;
          dec.unit = funct3[2] ? unit_division : unit_mult;
          dec.op.division = funct3[2];
          dec.op.mult = ~funct3[2];
          dec.op.valid = 1'b1;
        end else begin
          dec.alu_op = alu_from_funct(funct3, instr[30]);
          dec.op.valid = (funct7 == funct7_base) ||
                         (funct7 == funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        end
      end
      op_jal: begin
        complex_class = 1'b1;
        dec.unit = unit_branch;
        dec.imm = imm_j;
        dec.op.wren = 1'b1;
        dec.op.jal = 1'b1;
        dec.op.valid = 1'b1;
      end
      op_jalr: begin
        complex_class = 1'b1;
        dec.unit = unit_branch;
        dec.imm = imm_i;
        dec.op.wren = 1'b1;
        dec.op.rden1 = 1'b1;
        dec.op.jalr = 1'b1;
        dec.op.valid = (funct3 == 3'b000);
      end
      op_branch: begin
        complex_class = 1'b1;
        dec.unit = unit_branch;
        dec.imm = imm_b;
        dec.op.rden1 = 1'b1;
        dec.op.rden2 = 1'b1;
        dec.op.branch = 1'b1;
        dec.op.valid = (funct3[2:1] != 2'b01); // 010 and 011 are reserved.
      end
      op_load: begin
        complex_class = 1'b1;
        dec.unit = unit_load;
        dec.imm = imm_i;
        dec.op.wren = 1'b1;
        dec.op.rden1 = 1'b1;
        dec.op.load = 1'b1;
        dec.op.valid = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
      end
      op_store: begin
        complex_class = 1'b1;
        dec.unit = unit_store;
        dec.imm = imm_s;
        dec.op.rden1 = 1'b1;
        dec.op.rden2 = 1'b1;
        dec.op.store = 1'b1;
        dec.op.valid = (funct3 < 3'b011);
      end
      op_fence: begin
        complex_class = 1'b1;
        dec.unit = unit_system;
        dec.op.fence = 1'b1;
        dec.op.valid = (funct3[2:1] == 2'b00); // Fence and fence.i.
      end
      op_system: begin
        complex_class = 1'b1;
        if (funct3 == 3'b000) begin
          dec.unit = unit_system;
          dec.op.ecall = (instr == instr_ecall);
          dec.op.ebreak = (instr == instr_ebreak);
          dec.op.mret = (instr == instr_mret);
          dec.op.valid = dec.op.ecall | dec.op.ebreak | dec.op.mret;
        end else if (funct3 != 3'b100) begin
          dec.unit = unit_csr;
          dec.imm = {{(xlen-reg_addr_width){1'b0}}, rs1}; // zimm for the immediate forms.
          dec.op.wren = 1'b1;
          dec.op.rden1 = ~funct3[2];
          if (funct3[1:0] == 2'b01) begin
            dec.op.csr_write = 1'b1;
            dec.op.csr_read = (rd != '0);
          end else begin
            dec.op.csr_read = 1'b1;
            dec.op.csr_write = (rs1 != '0);
          end
          dec.op.valid = 1'b1;
        end
      end
      default: ;
    endcase
    // Slot 1 treats the complex classes as unknown encodings.
    if (!dec.op.valid || (complex_class && !full)) dec.op = init_operation;
    assert ($onehot0({dec.op.load, dec.op.store, dec.op.branch, dec.op.mult, dec.op.division}));
  end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file import decode_pkg::*; (
  input logic clock,
  input logic reset,
  input read_port_type read0_1,
  input read_port_type read0_2,
  input read_port_type read1_1,
  input read_port_type read1_2,
  output logic [xlen-1:0] rdata0_1,
  output logic [xlen-1:0] rdata0_2,
  output logic [xlen-1:0] rdata1_1,
  output logic [xlen-1:0] rdata1_2,
  input writeback_type wb
);

  logic [xlen-1:0] regs [2**reg_addr_width];

  // Disabled ports and x0 read as zero.
  assign rdata0_1 = (read0_1.rden && read0_1.raddr != '0) ? regs[read0_1.raddr] : '0;
  assign rdata0_2 = (read0_2.rden && read0_2.raddr != '0) ? regs[read0_2.raddr] : '0;
  assign rdata1_1 = (read1_1.rden && read1_1.raddr != '0) ? regs[read1_1.raddr] : '0;
  assign rdata1_2 = (read1_2.rden && read1_2.raddr != '0) ? regs[read1_2.raddr] : '0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wren && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata; // No bypass to the read side.
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    wb.wren |-> !$isunknown(wb.waddr));

endmodule
